//--- src/heap_pkg.sv
package heap_pkg;

  // --------------------------------------------------------------------------
  // Heap geometry
  // --------------------------------------------------------------------------
  localparam int HEAP_LEVELS = 4;                      // Tree levels, one RAM each
  localparam int HEAP_CAP    = (1 << HEAP_LEVELS) - 1; // 15 keys when full
  localparam int KEY_W       = 16;                     // Key width

  // Address into the widest level
  localparam int ADDR_W = HEAP_LEVELS - 1;
  // Element count, holds 0 .. HEAP_CAP
  localparam int CNT_W  = $clog2(HEAP_CAP + 1);
  // Level number of a node
  localparam int LVL_W  = $clog2(HEAP_LEVELS);

  // --------------------------------------------------------------------------
  // Sift controller state encoding
  // --------------------------------------------------------------------------
  localparam int ST_W = 4;

  localparam logic [ST_W-1:0] ST_IDLE     = 4'd0; // Waiting for a strobe
  localparam logic [ST_W-1:0] ST_UP_WAIT  = 4'd1; // Parent read in flight
  localparam logic [ST_W-1:0] ST_UP_CMP   = 4'd2; // Parent vs moving key
  localparam logic [ST_W-1:0] ST_POP_WAIT = 4'd3; // Root and last slot in flight
  localparam logic [ST_W-1:0] ST_POP_CAP  = 4'd4; // Root out, last slot captured
  localparam logic [ST_W-1:0] ST_DN_RDR   = 4'd5; // Left child read, right next
  localparam logic [ST_W-1:0] ST_DN_CL    = 4'd6; // Capture left child
  localparam logic [ST_W-1:0] ST_DN_CMP   = 4'd7; // Larger child vs moving key
  localparam logic [ST_W-1:0] ST_FIN      = 4'd8; // Last write lands in the RAM

endpackage

//--- src/level_ram.sv
module level_ram
  import heap_pkg::*;
#(
  parameter int LEVEL = 0  // Heap level held here
) (
  input  logic              CLK,
  input  logic              i_en,    // Port enable
  input  logic              i_we,    // Write when enabled
  input  logic [ADDR_W-1:0] i_addr,  // Only low LEVEL bits matter
  input  logic [KEY_W-1:0]  i_wdata,
  output logic [KEY_W-1:0]  o_rdata  // Registered read word
);

  // One word per node on this level
  logic [KEY_W-1:0]  mem [2**LEVEL];
  logic [ADDR_W-1:0] row;

  // Mask off the upper address bits
  assign row = i_addr & ADDR_W'((1 << LEVEL) - 1);

  // Single port, read-first is irrelevant since a write keeps o_rdata
  always_ff @(posedge CLK) begin
    if (i_en) begin
      // Word decode
      for (int w = 0; w < 2**LEVEL; w++) begin
        if (row == ADDR_W'(w)) begin
          if (i_we) begin
            mem[w] <= i_wdata;  // Store, output held
          end else begin
            o_rdata <= mem[w];  // Visible after this edge
          end
        end
      end
    end
  end

endmodule

//--- src/heap_sift_ctrl.sv
module heap_sift_ctrl
  import heap_pkg::*;
(
  input  logic              CLK,
  input  logic              RSTn,
  // User side
  input  logic              i_push,
  input  logic              i_pop,
  input  logic [KEY_W-1:0]  i_key,
  output logic              o_pop_valid,
  output logic [KEY_W-1:0]  o_pop_key,
  output logic              o_full,
  output logic              o_empty,
  output logic              o_busy,
  // One RAM port group per level
  output logic              o_ram_en    [HEAP_LEVELS],
  output logic              o_ram_we    [HEAP_LEVELS],
  output logic [ADDR_W-1:0] o_ram_addr  [HEAP_LEVELS],
  output logic [KEY_W-1:0]  o_ram_wdata [HEAP_LEVELS],
  input  logic [KEY_W-1:0]  i_ram_rdata [HEAP_LEVELS]
);

  // --------------------------------------------------------------------------
  // State and next-state signals
  // --------------------------------------------------------------------------
  logic [ST_W-1:0]   state, state_nxt;
  logic [CNT_W-1:0]  cnt, cnt_nxt;     // Keys held
  logic [KEY_W-1:0]  mkey, mkey_nxt;   // Moving key
  logic [KEY_W-1:0]  ckey, ckey_nxt;   // Left child held during right read
  logic [LVL_W-1:0]  lvl, lvl_nxt;     // Current node level
  logic [ADDR_W-1:0] idx, idx_nxt;     // Current node index in its level
  logic              rvld, rvld_nxt;   // Right child exists
  logic              pvld_nxt;
  logic [KEY_W-1:0]  pkey_nxt;

  logic              en_nxt    [HEAP_LEVELS];
  logic              we_nxt    [HEAP_LEVELS];
  logic [ADDR_W-1:0] addr_nxt  [HEAP_LEVELS];
  logic [KEY_W-1:0]  wdata_nxt [HEAP_LEVELS];

  // Neighbour levels, wrap is harmless since bounds come from the count
  logic [LVL_W-1:0]  lvl_up, lvl_up2, lvl_dn, lvl_dn2;

  // Slot positions from the count
  logic [CNT_W-1:0]  new_n;
  logic [LVL_W-1:0]  new_lvl, new_up, last_lvl;
  logic [ADDR_W-1:0] new_idx, last_idx;

  // Sift-down helpers
  logic [CNT_W-1:0]  node_num;         // 1-based heap number of current node
  logic              rgt_ok, gc_ok;
  logic              big_side;         // 1 when right child wins
  logic [KEY_W-1:0]  big_key;

  // Level of 1-based heap number n, its top set bit
  function automatic logic [LVL_W-1:0] pos_lvl(input logic [CNT_W-1:0] n);
    logic [LVL_W-1:0] l;
    l = '0;
    for (int b = 0; b < CNT_W; b++) begin
      if (n[b]) l = LVL_W'(b);
    end
    return l;
  endfunction

  assign lvl_up  = lvl - 1'b1;
  assign lvl_up2 = lvl - 2'd2;
  assign lvl_dn  = lvl + 1'b1;
  assign lvl_dn2 = lvl + 2'd2;

  // New slot sits right after the last one
  assign new_n    = cnt + 1'b1;
  assign new_lvl  = pos_lvl(new_n);
  assign new_up   = new_lvl - 1'b1;
  assign new_idx  = ADDR_W'(new_n ^ (CNT_W'(1) << new_lvl));
  assign last_lvl = pos_lvl(cnt);
  assign last_idx = ADDR_W'(cnt ^ (CNT_W'(1) << last_lvl));

  // Children of node k are 2k and 2k+1, valid up to the count
  assign node_num = (CNT_W'(1) << lvl) | CNT_W'(idx);
  assign rgt_ok   = ({node_num, 1'b1} <= {1'b0, cnt});
  assign gc_ok    = ({node_num, big_side, 1'b0} <= {2'b00, cnt}); // Left grandchild

  // Right data is on the child RAM now, left is in ckey
  assign big_side = rvld && (i_ram_rdata[lvl_dn] > ckey);
  assign big_key  = big_side ? i_ram_rdata[lvl_dn] : ckey;

  assign o_full  = (cnt == CNT_W'(HEAP_CAP));
  assign o_empty = (cnt == '0);
  assign o_busy  = (state != ST_IDLE);

  // --------------------------------------------------------------------------
  // Next-state logic
  // --------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    mkey_nxt  = mkey;
    ckey_nxt  = ckey;
    lvl_nxt   = lvl;
    idx_nxt   = idx;
    rvld_nxt  = rvld;
    pvld_nxt  = 1'b0;       // Single-cycle strobe
    pkey_nxt  = o_pop_key;
    for (int n = 0; n < HEAP_LEVELS; n++) begin
      en_nxt[n]    = 1'b0;
      we_nxt[n]    = 1'b0;
      addr_nxt[n]  = o_ram_addr[n];
      wdata_nxt[n] = o_ram_wdata[n];
    end

    case (state)
      ST_IDLE: begin
        if (i_push) begin
          // Push wins over a simultaneous pop
          if (!o_full) begin
            cnt_nxt  = cnt + 1'b1;
            mkey_nxt = i_key;
            lvl_nxt  = new_lvl;
            idx_nxt  = new_idx;
            if (new_lvl == '0) begin
              // Empty heap, key goes straight to the root
              en_nxt[0]    = 1'b1;
              we_nxt[0]    = 1'b1;
              addr_nxt[0]  = '0;
              wdata_nxt[0] = i_key;
              state_nxt    = ST_FIN;
            end else begin
              en_nxt[new_up]   = 1'b1;       // Read parent
              addr_nxt[new_up] = new_idx >> 1;
              state_nxt        = ST_UP_WAIT;
            end
          end
        end else if (i_pop && !o_empty) begin
          cnt_nxt     = cnt - 1'b1;
          lvl_nxt     = last_lvl;             // Remember where the last key sits
          idx_nxt     = last_idx;
          en_nxt[0]   = 1'b1;                 // Root read
          addr_nxt[0] = '0;
          if (last_lvl != '0) begin
            en_nxt[last_lvl]   = 1'b1;        // Last slot, other RAM
            addr_nxt[last_lvl] = last_idx;
          end
          state_nxt = ST_POP_WAIT;
        end
      end

      ST_UP_WAIT: state_nxt = ST_UP_CMP;

      ST_UP_CMP: begin
        if (mkey > i_ram_rdata[lvl_up]) begin
          // Parent moves down into the current slot
          en_nxt[lvl]    = 1'b1;
          we_nxt[lvl]    = 1'b1;
          addr_nxt[lvl]  = idx;
          wdata_nxt[lvl] = i_ram_rdata[lvl_up];
          lvl_nxt        = lvl_up;
          idx_nxt        = idx >> 1;
          if (lvl_up == '0) begin
            en_nxt[0]    = 1'b1;              // Reached the root
            we_nxt[0]    = 1'b1;
            addr_nxt[0]  = '0;
            wdata_nxt[0] = mkey;
            state_nxt    = ST_FIN;
          end else begin
            en_nxt[lvl_up2]   = 1'b1;         // Next parent up
            addr_nxt[lvl_up2] = idx >> 2;
            state_nxt         = ST_UP_WAIT;
          end
        end else begin
          en_nxt[lvl]    = 1'b1;              // Settle here
          we_nxt[lvl]    = 1'b1;
          addr_nxt[lvl]  = idx;
          wdata_nxt[lvl] = mkey;
          state_nxt      = ST_FIN;
        end
      end

      ST_POP_WAIT: state_nxt = ST_POP_CAP;

      ST_POP_CAP: begin
        pvld_nxt = 1'b1;
        pkey_nxt = i_ram_rdata[0];            // Old root
        mkey_nxt = i_ram_rdata[lvl];          // Old last key
        lvl_nxt  = '0;
        idx_nxt  = '0;
        if (cnt == '0) begin
          state_nxt = ST_IDLE;                // Heap drained, nothing to move
        end else if (cnt == CNT_W'(1)) begin
          en_nxt[0]    = 1'b1;                // Root has no children left
          we_nxt[0]    = 1'b1;
          addr_nxt[0]  = '0;
          wdata_nxt[0] = i_ram_rdata[lvl];
          state_nxt    = ST_FIN;
        end else begin
          en_nxt[1]   = 1'b1;                 // Left child of root
          addr_nxt[1] = '0;
          state_nxt   = ST_DN_RDR;
        end
      end

      ST_DN_RDR: begin
        // Children share one RAM, right follows left
        rvld_nxt = rgt_ok;
        if (rgt_ok) begin
          en_nxt[lvl_dn]   = 1'b1;
          addr_nxt[lvl_dn] = {idx[ADDR_W-2:0], 1'b1};
        end
        state_nxt = ST_DN_CL;
      end

      ST_DN_CL: begin
        ckey_nxt  = i_ram_rdata[lvl_dn];
        state_nxt = ST_DN_CMP;
      end

      ST_DN_CMP: begin
        if (big_key > mkey) begin
          // Larger child moves up
          en_nxt[lvl]    = 1'b1;
          we_nxt[lvl]    = 1'b1;
          addr_nxt[lvl]  = idx;
          wdata_nxt[lvl] = big_key;
          lvl_nxt        = lvl_dn;
          idx_nxt        = {idx[ADDR_W-2:0], big_side};
          if (gc_ok) begin
            en_nxt[lvl_dn2]   = 1'b1;
            addr_nxt[lvl_dn2] = {idx[ADDR_W-3:0], big_side, 1'b0};
            state_nxt         = ST_DN_RDR;
          end else begin
            en_nxt[lvl_dn]    = 1'b1;         // Leaf, moving key lands here
            we_nxt[lvl_dn]    = 1'b1;
            addr_nxt[lvl_dn]  = {idx[ADDR_W-2:0], big_side};
            wdata_nxt[lvl_dn] = mkey;
            state_nxt         = ST_FIN;
          end
        end else begin
          en_nxt[lvl]    = 1'b1;
          we_nxt[lvl]    = 1'b1;
          addr_nxt[lvl]  = idx;
          wdata_nxt[lvl] = mkey;
          state_nxt      = ST_FIN;
        end
      end

      ST_FIN: state_nxt = ST_IDLE;            // Write done on this edge

      default: state_nxt = ST_IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RSTn) begin
    if (!RSTn) begin
      state       <= ST_IDLE;
      cnt         <= '0;
      lvl         <= '0;
      idx         <= '0;
      rvld        <= 1'b0;
      o_pop_valid <= 1'b0;
      for (int n = 0; n < HEAP_LEVELS; n++) begin
        o_ram_en[n] <= 1'b0;
        o_ram_we[n] <= 1'b0;
      end
    end else begin
      state       <= state_nxt;
      cnt         <= cnt_nxt;
      lvl         <= lvl_nxt;
      idx         <= idx_nxt;
      rvld        <= rvld_nxt;
      o_pop_valid <= pvld_nxt;
      for (int n = 0; n < HEAP_LEVELS; n++) begin
        o_ram_en[n] <= en_nxt[n];
        o_ram_we[n] <= we_nxt[n];
      end
    end
  end

  // Key and address payload
  always_ff @(posedge CLK) begin
    mkey      <= mkey_nxt;
    ckey      <= ckey_nxt;
    o_pop_key <= pkey_nxt;
    for (int n = 0; n < HEAP_LEVELS; n++) begin
      o_ram_addr[n]  <= addr_nxt[n];
      o_ram_wdata[n] <= wdata_nxt[n];
    end
  end

endmodule

//--- src/heap_queue_top.sv
module heap_queue_top
  import heap_pkg::*;
(
  input  logic             CLK,
  input  logic             RSTn,
  // Commands
  input  logic             i_push,       // Insert strobe
  input  logic             i_pop,        // Remove-max strobe
  input  logic [KEY_W-1:0] i_key,        // Key for push
  // Results and status
  output logic             o_pop_valid,  // Pop result strobe
  output logic [KEY_W-1:0] o_pop_key,    // Old root
  output logic             o_full,
  output logic             o_empty,
  output logic             o_busy        // Strobes dropped while high
);

  // --------------------------------------------------------------------------
  // Per-level RAM ports
  // --------------------------------------------------------------------------
  logic              ram_en    [HEAP_LEVELS];
  logic              ram_we    [HEAP_LEVELS];
  logic [ADDR_W-1:0] ram_addr  [HEAP_LEVELS];
  logic [KEY_W-1:0]  ram_wdata [HEAP_LEVELS];
  logic [KEY_W-1:0]  ram_rdata [HEAP_LEVELS];

  // Count, sift FSM and RAM drive
  heap_sift_ctrl u_ctrl (
    .CLK         (CLK),
    .RSTn        (RSTn),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_key       (i_key),
    .o_pop_valid (o_pop_valid),
    .o_pop_key   (o_pop_key),
    .o_full      (o_full),
    .o_empty     (o_empty),
    .o_busy      (o_busy),
    .o_ram_en    (ram_en),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata),
    .i_ram_rdata (ram_rdata)
  );

  // --------------------------------------------------------------------------
  // One RAM per heap level, level L holds 2^L keys
  // --------------------------------------------------------------------------
  generate
    for (genvar g = 0; g < HEAP_LEVELS; g++) begin : gen_level
      level_ram #(
        .LEVEL (g)
      ) u_ram (
        .CLK     (CLK),
        .i_en    (ram_en[g]),
        .i_we    (ram_we[g]),
        .i_addr  (ram_addr[g]),
        .i_wdata (ram_wdata[g]),
        .o_rdata (ram_rdata[g])    // Back to the controller
      );
    end
  endgenerate

endmodule

//--- verif/heap_queue_assertions.sv
module heap_queue_assertions (
  input logic CLK,
  input logic RSTn,
  input logic i_push,
  input logic i_pop,
  input logic o_pop_valid,
  input logic o_full,
  input logic o_empty,
  input logic o_busy
);

  timeunit 1ns;
  timeprecision 1ps;

  logic push_ok;  // Push taken on this edge
  logic pop_ok;   // Pop taken on this edge when no push is strobed

  assign push_ok = i_push && !o_busy && !o_full;
  assign pop_ok  = i_pop && !i_push && !o_busy && !o_empty;

  // --------------------------------------------------------------------------
  // Port protocol
  // --------------------------------------------------------------------------
  full_empty_excl: assert property (@(posedge CLK) disable iff (!RSTn)
    !(o_full && o_empty))
    else $error("o_full and o_empty are high together");

  pop_valid_pulse: assert property (@(posedge CLK) disable iff (!RSTn)
    o_pop_valid |=> !o_pop_valid)
    else $error("o_pop_valid stayed high for two cycles");

  // Any accepted command starts a sift
  busy_after_cmd: assert property (@(posedge CLK) disable iff (!RSTn)
    (push_ok || pop_ok) |=> o_busy)
    else $error("accepted command did not raise o_busy");

  // Strobe set by edge N+2, so first seen at edge N+3
  pop_latency: assert property (@(posedge CLK) disable iff (!RSTn)
    pop_ok |-> ##3 o_pop_valid)
    else $error("o_pop_valid missing in the cycle after the second edge past a pop");

endmodule

// Attach to the top level ports
bind heap_queue_top heap_queue_assertions u_assertions (
  .CLK         (CLK),
  .RSTn        (RSTn),
  .i_push      (i_push),
  .i_pop       (i_pop),
  .o_pop_valid (o_pop_valid),
  .o_full      (o_full),
  .o_empty     (o_empty),
  .o_busy      (o_busy)
);

//--- verif/heap_queue_tb.sv
module heap_queue_tb
  import heap_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------------------------------
  // Run length
  // --------------------------------------------------------------------------
  localparam int PERIOD     = 10;
  localparam int RST_CYC    = 10;
  localparam int N_RAND     = 400;                       // Random command slots
  localparam int WORST_SIFT = 4 * HEAP_LEVELS + 4;       // Full-depth pop plus gap
  localparam int N_CMDS     = 4 * HEAP_CAP + 4 + 2 * N_RAND;
  localparam int TIMEOUT_NS = (N_CMDS * WORST_SIFT + RST_CYC + 100) * PERIOD;

  logic             CLK = 1'b0;
  logic             RSTn;
  logic             i_push;
  logic             i_pop;
  logic [KEY_W-1:0] i_key;
  logic             o_pop_valid;
  logic [KEY_W-1:0] o_pop_key;
  logic             o_full;
  logic             o_empty;
  logic             o_busy;

  integer           seed = 32'h5a5cab8e;
  int               errors = 0;
  int               cyc = 0;          // Rising edges seen
  int               n_pops = 0;       // Pops accepted
  int               n_seen = 0;       // Pop results checked
  logic             order_chk = 1'b0; // Drain phase, keys must not rise
  logic [KEY_W-1:0] last_key = '1;

  logic [KEY_W-1:0] model [$];        // Keys the heap should hold
  logic [KEY_W-1:0] exp_q [$];        // Expected pop keys, oldest first
  int               acc_q [$];        // Accepting edge per pop
  logic [KEY_W-1:0] exp_key;
  int               acc_edge;

  heap_queue_top UUT (
    .CLK         (CLK),
    .RSTn        (RSTn),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_key       (i_key),
    .o_pop_valid (o_pop_valid),
    .o_pop_key   (o_pop_key),
    .o_full      (o_full),
    .o_empty     (o_empty),
    .o_busy      (o_busy)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Largest key held, removed from the model
  function automatic logic [KEY_W-1:0] ref_pop_max();
    int               best;
    logic [KEY_W-1:0] k;
    best = 0;
    for (int n = 1; n < model.size(); n++) begin
      if (model[n] > model[best]) best = n;
    end
    k = model[best];
    model.delete(best);
    return k;
  endfunction

  function automatic logic [KEY_W-1:0] rand_key();
    logic [31:0] r;
    r = $random(seed);
    if (r[31]) return KEY_W'(r[2:0]);  // Tiny range, repeats are common
    return KEY_W'(r);
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  // Flags follow the model count
  task automatic check_status();
    check_level("o_full", o_full, model.size() == HEAP_CAP);
    check_level("o_empty", o_empty, model.size() == 0);
  endtask

  // One command slot, taken on the next rising edge if the rules allow
  task automatic issue(input logic push, input logic pop, input logic [KEY_W-1:0] key);
    @(negedge CLK);
    check_status();
    i_push = push;
    i_pop  = pop;
    i_key  = key;
    if (!o_busy) begin
      if (push) begin
        if (model.size() < HEAP_CAP) model.push_back(key);  // Full heap drops it
      end else if (pop && model.size() > 0) begin
        exp_q.push_back(ref_pop_max());
        acc_q.push_back(cyc + 1);        // Edge that accepts it
        n_pops++;
      end
    end
  endtask

  task automatic quiet();
    @(negedge CLK);
    check_status();
    i_push = 1'b0;
    i_pop  = 1'b0;
  endtask

  task automatic wait_ready();
    quiet();
    while (o_busy) quiet();
  endtask

  // --------------------------------------------------------------------------
  // Compare process, outputs sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge CLK) begin
    if (RSTn && o_pop_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("o_pop_valid came with no accepted pop waiting, key %h", o_pop_key);
        errors++;
      end
      if (exp_q.size() > 0) begin
        exp_key  = exp_q.pop_front();
        acc_edge = acc_q.pop_front();
        n_seen++;
        assert (o_pop_key == exp_key) else begin
          $display("mismatch o_pop_key: expected %h, got %h", exp_key, o_pop_key);
          errors++;
        end
        assert (cyc == acc_edge + 2) else begin
          $display("o_pop_valid came %0d cycles after its pop was accepted, not 2",
                   cyc - acc_edge);
          errors++;
        end
        if (order_chk) begin
          assert (o_pop_key <= last_key) else begin
            $display("pop order broken, key %h came after %h", o_pop_key, last_key);
            errors++;
          end
          last_key = o_pop_key;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    int sel;
    RSTn   = 1'b0;
    i_push = 1'b0;
    i_pop  = 1'b0;
    i_key  = '0;
    repeat (RST_CYC) @(posedge CLK);
    @(negedge CLK);
    RSTn = 1'b1;

    // Idle state after reset
    @(negedge CLK);
    check_level("o_empty", o_empty, 1'b1);
    check_level("o_full", o_full, 1'b0);
    check_level("o_busy", o_busy, 1'b0);
    check_level("o_pop_valid", o_pop_valid, 1'b0);
    last_key  = '1;
    order_chk = 1'b1;

    for (int n = 0; n < HEAP_CAP; n++) begin  // Fill to capacity
      issue(1'b1, 1'b0, rand_key());
      wait_ready();
    end
    check_level("o_full", o_full, 1'b1);

    // Extra push must be dropped
    issue(1'b1, 1'b0, rand_key());
    quiet();
    assert (!o_busy) else begin
      $display("push into a full heap was taken, the queue went busy");
      errors++;
    end

    for (int n = 0; n < HEAP_CAP; n++) begin  // Drain, largest first
      issue(1'b0, 1'b1, '0);
      wait_ready();
    end
    quiet();
    order_chk = 1'b0;

    // Pop on an empty heap
    check_level("o_empty", o_empty, 1'b1);
    issue(1'b0, 1'b1, '0);
    repeat (3) begin
      quiet();
      assert (!o_busy) else begin
        $display("pop on an empty heap was taken, the queue went busy");
        errors++;
      end
    end

    // Random mix, strobes land during busy too
    for (int n = 0; n < N_RAND; n++) begin
      sel = $random(seed) & 7;
      issue((sel <= 2) || (sel == 6), (sel >= 3) && (sel <= 6), rand_key());
    end
    wait_ready();
    while (model.size() > 0) begin
      issue(1'b0, 1'b1, '0);
      wait_ready();
    end
    repeat (3) quiet();

    assert (exp_q.size() == 0) else begin
      $display("%0d accepted pops never returned a result", exp_q.size());
      errors++;
    end
    $display("Pops checked: %0d of %0d, errors: %0d", n_seen, n_pops, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Pops checked: %0d of %0d, errors: %0d", n_seen, n_pops, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- files.f
src/heap_pkg.sv
src/level_ram.sv
src/heap_sift_ctrl.sv
src/heap_queue_top.sv
verif/heap_queue_assertions.sv
verif/heap_queue_tb.sv

//--- Makefile
TOP = heap_queue_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
	  --top-module $(TOP) -f files.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir
